// ==== hw/esfa_settings.svh ====
// table depth, index width, aggregate selector code and evaluation latency
`ifndef ESFA_SETTINGS_SVH
`define ESFA_SETTINGS_SVH

// ----------------------------------------------------------------------
// element tables
// ----------------------------------------------------------------------
`define ESFA_ENTRIES 8            // entries per table
`define ESFA_INDEX_BITS 3         // only the low bits of an index count

// ----------------------------------------------------------------------
// query decode
// ----------------------------------------------------------------------
`define ESFA_AGGREGATE_SELECTOR 8 // above this, bad selector

// selector update to valid combiner output
// table read takes one cycle, combine takes one
`define ESFA_EVAL_CYCLES 2

`endif

// ==== hw/hostLinkPkg.sv ====
// host link types: control byte, status byte, process FSM states
package hostLinkPkg;

  // ----------------------------------------------------------------------
  // byte layouts on the host link
  // ----------------------------------------------------------------------

  // control byte as delivered by the bridge
  typedef struct packed
  {
    logic [5:0] reserved;    // ignored
    logic       isMetadata;  // write goes to limit table
    logic       isMutating;  // write, else query
  } controlByte;

  // status byte sent back with every answer
  typedef struct packed
  {
    logic [5:0] reserved;    // always zero
    logic       badSelector; // selector above aggregate code
    logic       resultFlag;  // ack on writes, comparison flag on queries
  } statusByte;

  // ----------------------------------------------------------------------
  // process FSM
  // ----------------------------------------------------------------------
  typedef enum logic [2:0]
  {
    psIdle,      // waiting for dataReceived
    psEvaluate,  // table write or evaluation pipeline in flight
    psRequest,   // capture answer, raise transmitData
    psHold,      // spacer before clearDR
    psComplete,  // raise clearDR
    psRelease    // wait for host to drop dataReceived
  } processState;

endpackage

// ==== hw/esfaPkg.sv ====
// element table types: write strobe, table readout, evaluation result, command opcodes
`include "esfa_settings.svh"

package esfaPkg;

  // ----------------------------------------------------------------------
  // table side
  // ----------------------------------------------------------------------

  // single entry write, strobe lasts one cycle
  typedef struct packed
  {
    logic                        strobe;
    logic [`ESFA_INDEX_BITS-1:0] index;
    logic [7:0]                  data;
  } entryWrite;

  // registered output of either table
  typedef struct packed
  {
    logic [7:0] selected; // entry named by selector
    logic [7:0] reduced;  // max for values, min for limits
  } tableReadout;

  // ----------------------------------------------------------------------
  // combiner side
  // ----------------------------------------------------------------------
  typedef struct packed
  {
    logic       resultBool;  // value above limit
    logic [7:0] resultValue;
    logic       badSelector;
  } evalResult;

  // decoded command, from isMutating / isMetadata
  typedef enum logic [1:0]
  {
    opQuery,
    opWriteValue,
    opWriteLimit
  } commandOp;

endpackage

// ==== hw/sandboxProcess.sv ====
// host protocol FSM: command decode, table write strobes, selector register, answer formatting
`timescale 1ns/1ps
`include "esfa_settings.svh"

module sandboxProcess
(
  input  logic                   masterClock,
  input  logic                   reset,        // active low, sync
  input  logic                   dataReceived, // bridge has a command
  input  hostLinkPkg::controlByte control,
  input  logic [31:0]            inputData,    // selector, limit, value, index
  input  esfaPkg::evalResult     evaluation,   // from combiner
  output esfaPkg::entryWrite     valueWrite,
  output esfaPkg::entryWrite     limitWrite,
  output logic [7:0]             selector,
  output logic                   startPulse,   // to blink indicator
  output logic                   clearDR,
  output logic                   transmitData,
  output hostLinkPkg::statusByte status,
  output logic [31:0]            outputData
);

  hostLinkPkg::processState state;
  esfaPkg::commandOp        decodedOp; // from the incoming control byte
  esfaPkg::commandOp        currentOp; // held for the running command
  logic [1:0]               evalCount; // cycles left in psEvaluate

  // ----------------------------------------------------------------------
  // command decode
  // ----------------------------------------------------------------------
  always_comb
  begin
    if (!control.isMutating)
    begin
      decodedOp = esfaPkg::opQuery;
    end
    else if (control.isMetadata)
    begin
      decodedOp = esfaPkg::opWriteLimit; // metadata means limits
    end
    else
    begin
      decodedOp = esfaPkg::opWriteValue;
    end
  end

  // ----------------------------------------------------------------------
  // protocol FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state        <= hostLinkPkg::psIdle;
      currentOp    <= esfaPkg::opQuery;
      evalCount    <= 2'd0;
      valueWrite   <= '0;
      limitWrite   <= '0;
      selector     <= 8'(`ESFA_AGGREGATE_SELECTOR); // park on aggregate
      startPulse   <= 1'b0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
      status       <= '0;
      outputData   <= 32'h0;
    end
    else
    begin
      // single-cycle pulses by default
      valueWrite.strobe <= 1'b0;
      limitWrite.strobe <= 1'b0;
      startPulse        <= 1'b0;

      case (state)
        hostLinkPkg::psIdle:
        begin
          if (dataReceived)
          begin
            currentOp  <= decodedOp;
            startPulse <= 1'b1;
            case (decodedOp)
              esfaPkg::opWriteValue:
              begin
                valueWrite <= '{strobe: 1'b1,
                                index:  inputData[`ESFA_INDEX_BITS-1:0],
                                data:   inputData[15:8]};
                evalCount  <= 2'd0;     // one cycle, then answer
              end
              esfaPkg::opWriteLimit:
              begin
                limitWrite <= '{strobe: 1'b1,
                                index:  inputData[`ESFA_INDEX_BITS-1:0],
                                data:   inputData[23:16]};
                evalCount  <= 2'd0;
              end
              default:
              begin
                selector  <= inputData[31:24];
                evalCount <= 2'(`ESFA_EVAL_CYCLES - 1); // read + combine
              end
            endcase
            state <= hostLinkPkg::psEvaluate;
          end
        end

        hostLinkPkg::psEvaluate:
        begin
          if (evalCount == 2'd0)
          begin
            state <= hostLinkPkg::psRequest;
          end
          else
          begin
            evalCount <= evalCount - 2'd1;
          end
        end

        hostLinkPkg::psRequest:
        begin
          transmitData <= 1'b1;
          if (currentOp == esfaPkg::opQuery)
          begin
            status     <= '{reserved:    6'h0,
                            badSelector: evaluation.badSelector,
                            resultFlag:  evaluation.resultBool};
            outputData <= {evaluation.resultValue, 24'h0}; // result in top byte
          end
          else
          begin
            status     <= '{reserved: 6'h0, badSelector: 1'b0, resultFlag: 1'b1}; // ack
            outputData <= 32'h0;
          end
          state <= hostLinkPkg::psHold;
        end

        hostLinkPkg::psHold:
        begin
          state <= hostLinkPkg::psComplete;
        end

        hostLinkPkg::psComplete:
        begin
          clearDR <= 1'b1; // answer ready for the host
          state   <= hostLinkPkg::psRelease;
        end

        hostLinkPkg::psRelease:
        begin
          // host may hold dataReceived as long as it likes
          if (!dataReceived)
          begin
            transmitData <= 1'b0;
            clearDR      <= 1'b0;
            state        <= hostLinkPkg::psIdle;
          end
        end

        default:
        begin
          state <= hostLinkPkg::psIdle;
        end
      endcase
    end
  end

endmodule

// ==== hw/valueTable.sv ====
// value table: entry store, registered selected read, running maximum
`timescale 1ns/1ps
`include "esfa_settings.svh"

module valueTable
(
  input  logic                 masterClock,
  input  logic                 reset,
  input  esfaPkg::entryWrite   write,
  input  logic [7:0]           selector,
  output esfaPkg::tableReadout readout
);

  logic [7:0] entries [`ESFA_ENTRIES];
  logic [7:0] maxValue;

  // entry store, values start at zero
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      for (int i = 0; i < `ESFA_ENTRIES; i++)
      begin
        entries[i] <= 8'h00;
      end
    end
    else if (write.strobe)
    begin
      entries[write.index] <= write.data;
    end
  end

  // largest entry across the table
  always_comb
  begin
    maxValue = entries[0];
    for (int i = 1; i < `ESFA_ENTRIES; i++)
    begin
      if (entries[i] > maxValue)
      begin
        maxValue = entries[i];
      end
    end
  end

  // readout refreshes every cycle
  always_ff @(posedge masterClock)
  begin
    readout.selected <= entries[selector[`ESFA_INDEX_BITS-1:0]]; // low bits only
    readout.reduced  <= maxValue;
  end

endmodule

// ==== hw/limitTable.sv ====
// limit table: entry store, registered selected read, running minimum
`timescale 1ns/1ps
`include "esfa_settings.svh"

module limitTable
(
  input  logic                 masterClock,
  input  logic                 reset,
  input  esfaPkg::entryWrite   write,
  input  logic [7:0]           selector,
  output esfaPkg::tableReadout readout
);

  logic [7:0] entries [`ESFA_ENTRIES];
  logic [7:0] minLimit;

  // limits start wide open
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      for (int i = 0; i < `ESFA_ENTRIES; i++)
      begin
        entries[i] <= 8'hFF;
      end
    end
    else if (write.strobe)
    begin
      entries[write.index] <= write.data;
    end
  end

  // tightest limit across the table
  always_comb
  begin
    minLimit = entries[0];
    for (int i = 1; i < `ESFA_ENTRIES; i++)
    begin
      if (entries[i] < minLimit)
      begin
        minLimit = entries[i];
      end
    end
  end

  // readout refreshes every cycle
  always_ff @(posedge masterClock)
  begin
    readout.selected <= entries[selector[`ESFA_INDEX_BITS-1:0]];
    readout.reduced  <= minLimit; // paired with max value for aggregate
  end

endmodule

// ==== hw/resultCombiner.sv ====
// registered compare of value and limit readouts into the evaluation result
`timescale 1ns/1ps
`include "esfa_settings.svh"

module resultCombiner
(
  input  logic                 masterClock,
  input  logic                 reset,
  input  logic [7:0]           selector,
  input  esfaPkg::tableReadout values,
  input  esfaPkg::tableReadout limits,
  output esfaPkg::evalResult   result
);

  // readouts lag the selector by one cycle
  logic [7:0] selectorDelayed;

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      selectorDelayed <= 8'(`ESFA_AGGREGATE_SELECTOR);
      result          <= '0;
    end
    else
    begin
      selectorDelayed <= selector;

      if (selectorDelayed < `ESFA_AGGREGATE_SELECTOR)
      begin
        // single entry
        result <= '{resultBool:  values.selected > limits.selected,
                    resultValue: values.selected,
                    badSelector: 1'b0};
      end
      else if (selectorDelayed == `ESFA_AGGREGATE_SELECTOR)
      begin
        // aggregate: largest value vs smallest limit
        result <= '{resultBool:  values.reduced > limits.reduced,
                    resultValue: values.reduced,
                    badSelector: 1'b0};
      end
      else
      begin
        result <= '{resultBool: 1'b0, resultValue: 8'h00, badSelector: 1'b1}; // out of range
      end
    end
  end

endmodule

// ==== hw/activityIndicator.sv ====
// slow clock synchronizer and blink FSM driving rxIndicator
`timescale 1ns/1ps

module activityIndicator
(
  input  logic masterClock,
  input  logic reset,
  input  logic slowClock,   // unrelated slow clock, sampled as data
  input  logic startPulse,  // one cycle, command started
  output logic rxIndicator
);

  typedef enum logic [2:0]
  {
    blIdle,      // waiting for a start
    blArmed,     // wait for slow high
    blAwaitFall, // light on next low
    blLit,       // wait for slow high again
    blAwaitOff   // dark on next low
  } blinkState;

  blinkState  state;
  logic       slowMeta;  // first sync stage
  logic       slowSync;

  // ----------------------------------------------------------------------
  // two-flop synchronizer
  // ----------------------------------------------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      slowMeta <= 1'b0;
      slowSync <= 1'b0;
    end
    else
    begin
      slowMeta <= slowClock;
      slowSync <= slowMeta;
    end
  end

  // ----------------------------------------------------------------------
  // blink FSM, starts inside a blink are dropped
  // ----------------------------------------------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state       <= blIdle;
      rxIndicator <= 1'b0;
    end
    else
    begin
      case (state)
        blIdle:
        begin
          if (startPulse)
          begin
            state <= blArmed;
          end
        end
        blArmed:
        begin
          if (slowSync)
          begin
            state <= blAwaitFall;
          end
        end
        blAwaitFall:
        begin
          if (!slowSync)
          begin
            rxIndicator <= 1'b1; // led on
            state       <= blLit;
          end
        end
        blLit:
        begin
          if (slowSync)
          begin
            state <= blAwaitOff;
          end
        end
        blAwaitOff:
        begin
          if (!slowSync)
          begin
            rxIndicator <= 1'b0;
            state       <= blIdle;
          end
        end
        default:
        begin
          rxIndicator <= 1'b0;
          state       <= blIdle;
        end
      endcase
    end
  end

endmodule

// ==== hw/sandboxTop.sv ====
// top level: process FSM, value and limit tables, combiner, activity indicator
`timescale 1ns/1ps

module sandboxTop
(
  input  logic                   masterClock,
  input  logic                   reset,
  input  logic                   slowClock,
  input  logic                   dataReceived,
  input  hostLinkPkg::controlByte control,
  input  logic [31:0]            inputData,
  output logic                   clearDR,
  output logic                   transmitData,
  output logic                   rxIndicator,
  output hostLinkPkg::statusByte status,
  output logic [31:0]            outputData
);

  esfaPkg::entryWrite   valueWrite;
  esfaPkg::entryWrite   limitWrite;
  esfaPkg::tableReadout valueReadout;
  esfaPkg::tableReadout limitReadout;
  esfaPkg::evalResult   evaluation;
  logic [7:0]           selector;   // shared by both tables and combiner
  logic                 startPulse;

  // ----------------------------------------------------------------------
  // host protocol
  // ----------------------------------------------------------------------
  sandboxProcess process
  (
    .masterClock  (masterClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .evaluation   (evaluation),
    .valueWrite   (valueWrite),
    .limitWrite   (limitWrite),
    .selector     (selector),
    .startPulse   (startPulse),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData)
  );

  // ----------------------------------------------------------------------
  // tables side by side, merged in the combiner
  // ----------------------------------------------------------------------
  valueTable values
  (
    .masterClock (masterClock),
    .reset       (reset),
    .write       (valueWrite),
    .selector    (selector),
    .readout     (valueReadout)
  );

  limitTable limits
  (
    .masterClock (masterClock),
    .reset       (reset),
    .write       (limitWrite),
    .selector    (selector),
    .readout     (limitReadout)
  );

  resultCombiner combiner
  (
    .masterClock (masterClock),
    .reset       (reset),
    .selector    (selector),
    .values      (valueReadout),
    .limits      (limitReadout),
    .result      (evaluation)
  );

  activityIndicator indicator
  (
    .masterClock (masterClock),
    .reset       (reset),
    .slowClock   (slowClock),
    .startPulse  (startPulse),
    .rxIndicator (rxIndicator)
  );

endmodule

// ==== dv/sandboxTb_chk.sv ====
// bound protocol assertions on the sandbox host-link outputs
`timescale 1ns/1ps

module sandboxChk
(
  input logic                   masterClock,
  input logic                   reset,
  input logic                   clearDR,
  input logic                   transmitData,
  input hostLinkPkg::statusByte status,
  input logic [31:0]            outputData
);

  // ----------------------------------------------------------------------
  // handshake ordering
  // ----------------------------------------------------------------------
  clearImpliesTransmit: assert property
    (@(posedge masterClock) disable iff (!reset) clearDR |-> transmitData)
    else $error("clearDR high without transmitData");

  // both flags come out of reset low
  quietAfterReset: assert property
    (@(posedge masterClock) !reset |=> (!transmitData && !clearDR))
    else $error("transmitData or clearDR high in the cycle after reset");

  // ----------------------------------------------------------------------
  // answer contents
  // ----------------------------------------------------------------------
  reservedZero: assert property
    (@(posedge masterClock) disable iff (!reset) status.reserved == 6'h0)
    else $error("status reserved bits not zero");

  // answer frozen while the host reads it
  answerStable: assert property
    (@(posedge masterClock) disable iff (!reset)
      ($past(clearDR) && clearDR) |-> ($stable(status) && $stable(outputData)))
    else $error("status or outputData changed while clearDR high");

endmodule

bind sandboxTop sandboxChk protocolChk
(
  .masterClock  (masterClock),
  .reset        (reset),
  .clearDR      (clearDR),
  .transmitData (transmitData),
  .status       (status),
  .outputData   (outputData)
);

// ==== dv/sandboxTb.sv ====
// testbench: clocks, reset, host model, reference model, answer compare, timeout
`timescale 1ns/1ps
`include "esfa_settings.svh"

module sandboxTb;

  localparam int slowPeriod      = 16;  // masterClock cycles per slowClock period
  localparam int randomRounds    = 16;  // write, entry query, aggregate query
  localparam int holdCommands    = 8;
  localparam int blinkCommands   = 4;
  localparam int totalCommands   = (`ESFA_AGGREGATE_SELECTOR + 1) + 3 * randomRounds
                                   + (255 - `ESFA_AGGREGATE_SELECTOR) + holdCommands
                                   + blinkCommands;
  localparam int timeoutCycles   = 100 * totalCommands;
  localparam int blinkRiseLimit  = 2 * slowPeriod + 4; // plus sync latency
  localparam int blinkFallLimit  = 2 * slowPeriod;

  logic                   masterClock;
  logic                   reset;
  logic                   slowClock;
  logic                   dataReceived;
  hostLinkPkg::controlByte control;
  logic [31:0]            inputData;
  logic                   clearDR;
  logic                   transmitData;
  logic                   rxIndicator;
  hostLinkPkg::statusByte status;
  logic [31:0]            outputData;

  logic [7:0]  shadowValue [`ESFA_ENTRIES]; // reference copies of both tables
  logic [7:0]  shadowLimit [`ESFA_ENTRIES];
  logic [7:0]  expStatus;
  logic [31:0] expData;
  int          cycleCount;

  sandboxTop uut
  (
    .masterClock  (masterClock),
    .reset        (reset),
    .slowClock    (slowClock),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .rxIndicator  (rxIndicator),
    .status       (status),
    .outputData   (outputData)
  );

  // ----------------------------------------------------------------------
  // clocks
  // ----------------------------------------------------------------------
  initial
  begin
    masterClock = 1'b0;
    forever #5 masterClock = ~masterClock;
  end

  initial
  begin
    slowClock = 1'b0;
    forever
    begin
      repeat (slowPeriod / 2) @(negedge masterClock);
      slowClock = ~slowClock; // 8 fast cycles per half
    end
  end

  // ----------------------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------------------
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
    begin
      abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model, returns {status, outputData}
  // ----------------------------------------------------------------------
  function automatic logic [39:0] predictAnswer(input esfaPkg::commandOp op,
                                                input logic [31:0] data);
    logic [`ESFA_INDEX_BITS-1:0] index;
    logic [7:0]                  sel;
    logic [7:0]                  value;
    logic [7:0]                  limit;
    logic                        flag;
    logic                        bad;
    index = data[`ESFA_INDEX_BITS-1:0]; // upper index bits ignored
    sel   = data[31:24];
    value = 8'h00;
    limit = 8'hFF;
    flag  = 1'b0;
    bad   = 1'b0;
    if (op == esfaPkg::opWriteValue)
    begin
      shadowValue[index] = data[15:8];
      return {8'h01, 32'h0}; // ack only
    end
    if (op == esfaPkg::opWriteLimit)
    begin
      shadowLimit[index] = data[23:16];
      return {8'h01, 32'h0};
    end
    if (sel < `ESFA_AGGREGATE_SELECTOR)
    begin
      value = shadowValue[sel[`ESFA_INDEX_BITS-1:0]];
      limit = shadowLimit[sel[`ESFA_INDEX_BITS-1:0]];
      flag  = value > limit;
    end
    else if (sel == `ESFA_AGGREGATE_SELECTOR)
    begin
      for (int i = 0; i < `ESFA_ENTRIES; i++)
      begin
        value = (shadowValue[i] > value) ? shadowValue[i] : value; // largest value
        limit = (shadowLimit[i] < limit) ? shadowLimit[i] : limit; // smallest limit
      end
      flag = value > limit;
    end
    else
    begin
      bad = 1'b1;
    end
    return {6'h0, bad, flag, value, 24'h0};
  endfunction

  // ----------------------------------------------------------------------
  // host model
  // ----------------------------------------------------------------------
  task automatic sendCommand(input esfaPkg::commandOp op, input logic [31:0] data,
                             input int extraHold);
    logic [39:0] answer;
    answer       = predictAnswer(op, data);
    expStatus    = answer[39:32];
    expData      = answer[31:0];
    @(negedge masterClock);
    control      = '{reserved:   6'($urandom),
                     isMetadata: op == esfaPkg::opWriteLimit,
                     isMutating: op != esfaPkg::opQuery};
    inputData    = data;
    dataReceived = 1'b1;
    while (!clearDR)
    begin
      @(negedge masterClock);
    end
    repeat (extraHold)
    begin
      @(negedge masterClock);
      checkValue("clearDR", 32'(clearDR), 32'h1); // back-pressure keeps it up
    end
    dataReceived = 1'b0;
    while (clearDR)
    begin
      @(negedge masterClock);
    end
    checkValue("transmitData", 32'(transmitData), 32'h0); // drops with clearDR
  endtask

  // answer compare, every cycle clearDR is high
  always @(negedge masterClock)
  begin
    if (reset && clearDR)
    begin
      checkValue("status", 32'(status), 32'(expStatus));
      checkValue("outputData", outputData, expData);
    end
  end

  // blink must follow the command start
  task automatic watchBlink();
    int waited;
    waited = 0;
    @(posedge dataReceived);
    while (!rxIndicator)
    begin
      @(negedge masterClock);
      waited = waited + 1;
      if (waited > blinkRiseLimit)
      begin
        abortRun("rxIndicator did not rise within two slowClock periods of a command");
      end
    end
    waited = 0;
    while (rxIndicator)
    begin
      @(negedge masterClock);
      waited = waited + 1;
      if (waited > blinkFallLimit)
      begin
        abortRun("rxIndicator stayed high too long after a blink");
      end
    end
  endtask

  // cycle limit
  always @(posedge masterClock)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      abortRun("run exceeded its cycle limit, the DUT stopped answering");
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    logic [7:0] index;
    void'($urandom(32'h5100_08e7));
    reset         = 1'b0;
    dataReceived  = 1'b0;
    control       = '0;
    inputData     = 32'h0;
    cycleCount    = 0;
    for (int i = 0; i < `ESFA_ENTRIES; i++)
    begin
      shadowValue[i] = 8'h00;
      shadowLimit[i] = 8'hFF;
    end
    repeat (8) @(negedge masterClock);
    reset = 1'b1;
    @(negedge masterClock);
    checkValue("rxIndicator", 32'(rxIndicator), 32'h0);

    // every selector right after reset
    for (int s = 0; s <= `ESFA_AGGREGATE_SELECTOR; s++)
    begin
      sendCommand(esfaPkg::opQuery, {8'(s), 24'($urandom)}, 0);
    end

    // random writes, entry query, aggregate query
    for (int r = 0; r < randomRounds; r++)
    begin
      index = 8'($urandom);
      if ($urandom_range(1, 0) == 1)
      begin
        sendCommand(esfaPkg::opWriteLimit, {8'($urandom), 8'($urandom), 8'($urandom), index},
                    0);
      end
      else
      begin
        sendCommand(esfaPkg::opWriteValue, {8'($urandom), 8'($urandom), 8'($urandom), index},
                    0);
      end
      sendCommand(esfaPkg::opQuery, {5'h0, index[2:0], 24'($urandom)}, 0);
      sendCommand(esfaPkg::opQuery, {8'(`ESFA_AGGREGATE_SELECTOR), 24'($urandom)}, 0);
    end

    // out of range selectors
    for (int s = `ESFA_AGGREGATE_SELECTOR + 1; s <= 255; s++)
    begin
      sendCommand(esfaPkg::opQuery, {8'(s), 24'($urandom)}, 0);
    end

    // host holds dataReceived, mixed commands
    for (int h = 0; h < holdCommands; h++)
    begin
      sendCommand(esfaPkg::commandOp'($urandom_range(2, 0)),
                  {8'($urandom_range(9, 0)), 24'($urandom)}, $urandom_range(20, 1));
    end

    // blink indicator, started from quiet
    for (int b = 0; b < blinkCommands; b++)
    begin
      repeat (3 * slowPeriod) @(negedge masterClock);
      checkValue("rxIndicator", 32'(rxIndicator), 32'h0);
      fork
        sendCommand(esfaPkg::opQuery, {8'($urandom_range(8, 0)), 24'h0}, 0);
        watchBlink();
      join
    end

    @(negedge masterClock);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/hostLinkPkg.sv
hw/esfaPkg.sv
hw/sandboxProcess.sv
hw/valueTable.sv
hw/limitTable.sv
hw/resultCombiner.sv
hw/activityIndicator.sv
hw/sandboxTop.sv
dv/sandboxTb_chk.sv
dv/sandboxTb.sv
